//--- uart_pkg.sv
// line-side definitions for the uart
// serial word width, baud compare width, tx and rx FSM state enums
package uart_pkg;

    localparam int DATA_W = 8;   // bits per serial word
    localparam int BAUD_W = 16;  // width of baud compare value

    // transmitter FSM
    typedef enum logic [1:0]
    {
        TX_IDLE,
        TX_START,
        TX_TRANSMIT,
        TX_STOP
    } tx_state_t;

    // receiver FSM
    typedef enum logic [1:0]
    {
        RX_IDLE,
        RX_START,
        RX_RECEIVE,
        RX_STOP
    } rx_state_t;

endpackage : uart_pkg

//--- apb_pkg.sv
// bus-side definitions for the uart APB slave
// address width, register map enum, control and status bit positions
package apb_pkg;

    localparam int ADDR_W = 8;

    // word addresses of the register map
    typedef enum logic [7:0]
    {
        REG_CTRL   = 8'h00,
        REG_BAUD   = 8'h04,
        REG_STATUS = 8'h08,
        REG_TXDATA = 8'h0C,
        REG_RXDATA = 8'h10
    } reg_addr_t;

    // CTRL bits
    localparam int CTRL_TX_EN = 0;
    localparam int CTRL_RX_EN = 1;

    // STATUS bits
    localparam int ST_TX_BUSY  = 0;
    localparam int ST_TX_FULL  = 1;
    localparam int ST_RX_EMPTY = 2;
    localparam int ST_RX_OVR   = 3;  // sticky, cleared by STATUS read

endpackage : apb_pkg

//--- uart_fifo.sv
// synchronous FIFO for uart words
// circular buffer, read and write pointers, occupancy count, full and empty
module uart_fifo
    import uart_pkg::*;
#(
    parameter int DEPTH = 4
)
(
    input  logic              clk,
    input  logic              rstn,
    input  logic              push,
    input  logic [DATA_W-1:0] push_data,
    input  logic              pop,
    output logic [DATA_W-1:0] pop_data,
    output logic              full,
    output logic              empty
);

    localparam int AW = $clog2(DEPTH);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [AW:0]       count;
    logic              do_push;
    logic              do_pop;

    assign do_push  = push && !full;   // push while full is dropped
    assign do_pop   = pop && !empty;
    assign full     = count == (AW+1)'(DEPTH);
    assign empty    = count == '0;
    assign pop_data = mem[rd_ptr];     // head visible while not empty

    always_ff @(posedge clk)
        if (do_push)
            mem[wr_ptr] <= push_data;

    // pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk)
        if (!rstn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end

    // a push into an empty FIFO becomes the head
    a_push_head: assert property (@(posedge clk) disable iff (!rstn)
        (push && empty) |=> (!empty && (pop_data == $past(push_data))));

endmodule : uart_fifo

//--- uart_apb_regs.sv
// APB register stage of the uart
// CTRL and BAUD registers, STATUS with sticky rx overrun flag,
// TXDATA write into tx FIFO, RXDATA read and pop of rx FIFO
module uart_apb_regs
    import uart_pkg::*;
    import apb_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,
    // APB slave
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [ADDR_W-1:0] paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    // control to the line stages
    output logic              tx_en,
    output logic              rx_en,
    output logic [BAUD_W-1:0] comp,
    // tx FIFO write side
    output logic              tx_push,
    output logic [DATA_W-1:0] tx_push_data,
    input  logic              tx_full,
    input  logic              tx_busy,
    // rx FIFO read side
    output logic              rx_pop,
    input  logic [DATA_W-1:0] rx_data,
    input  logic              rx_empty,
    input  logic              rx_full,
    input  logic              rx_push_seen
);

    reg_addr_t   addr;
    logic        access;
    logic        wr_ok;
    logic        rd_acc;
    logic        addr_hit;
    logic        tx_blocked;
    logic        rx_ovr;
    logic [31:0] rd_val;

    assign addr       = reg_addr_t'(paddr);
    assign access     = psel && penable;     // no wait states
    assign rd_acc     = access && !pwrite;
    assign tx_blocked = pwrite && (addr == REG_TXDATA) && tx_full;
    assign wr_ok      = access && pwrite && !pslverr;

    assign pready  = access;
    assign pslverr = access && (!addr_hit || tx_blocked);
    assign prdata  = rd_acc ? rd_val : '0;

    assign tx_push      = wr_ok && (addr == REG_TXDATA);
    assign tx_push_data = pwdata[DATA_W-1:0];
    assign rx_pop       = rd_acc && (addr == REG_RXDATA) && addr_hit;

    // address decode and read mux
    always_comb
    begin
        addr_hit = 1'b1;
        rd_val   = '0;
        case (addr)
            REG_CTRL:
            begin
                rd_val[CTRL_TX_EN] = tx_en;
                rd_val[CTRL_RX_EN] = rx_en;
            end
            REG_BAUD:   rd_val[BAUD_W-1:0] = comp;
            REG_STATUS:
            begin
                rd_val[ST_TX_BUSY]  = tx_busy;
                rd_val[ST_TX_FULL]  = tx_full;
                rd_val[ST_RX_EMPTY] = rx_empty;
                rd_val[ST_RX_OVR]   = rx_ovr;
            end
            REG_TXDATA: rd_val = '0;             // write only
            REG_RXDATA:
                if (!rx_empty)
                    rd_val[DATA_W-1:0] = rx_data;
            default:    addr_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
        if (!rstn)
        begin
            tx_en <= 1'b0;
            rx_en <= 1'b0;
            comp  <= '0;
        end
        else if (wr_ok)
        begin
            if (addr == REG_CTRL)
            begin
                tx_en <= pwdata[CTRL_TX_EN];
                rx_en <= pwdata[CTRL_RX_EN];
            end
            if (addr == REG_BAUD)
                comp <= pwdata[BAUD_W-1:0];
        end

    // sticky overrun, a new drop wins over a clearing read
    always_ff @(posedge clk)
        if (!rstn)
            rx_ovr <= 1'b0;
        else if (rx_push_seen && rx_full)
            rx_ovr <= 1'b1;
        else if (rd_acc && (addr == REG_STATUS))
            rx_ovr <= 1'b0;

    // access phase only directly after a setup phase
    a_apb_setup: assert property (@(posedge clk) disable iff (!rstn)
        penable |-> $past(psel));

endmodule : uart_apb_regs

//--- uart_transmitter.sv
// uart 8N1 transmitter
// pops a byte from the tx FIFO and shifts it out LSB first,
// each bit held for comp+1 clock cycles
module uart_transmitter
    import uart_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,
    input  logic              tr_en,     // clearing it aborts the frame
    input  logic [BAUD_W-1:0] comp,
    input  logic [DATA_W-1:0] tx_data,
    input  logic              tx_empty,
    output logic              tx_pop,
    output logic              busy,
    output logic              uart_tx
);

    localparam int CNT_W = $clog2(DATA_W);

    tx_state_t         state;
    tx_state_t         next_state;
    logic [DATA_W-1:0] shift_reg;    // byte being sent
    logic [CNT_W-1:0]  bit_cnt;
    logic [BAUD_W-1:0] counter;      // baud counter
    logic              bit_done;
    logic              last_bit;

    assign bit_done = counter >= comp;
    assign last_bit = bit_cnt == CNT_W'(DATA_W - 1);
    assign tx_pop   = (state == TX_IDLE) && tr_en && !tx_empty;
    assign busy     = state != TX_IDLE;

    always_ff @(posedge clk)
        if (!rstn)
            state <= TX_IDLE;
        else
            state <= tr_en ? next_state : TX_IDLE;

    always_comb
    begin
        next_state = state;
        case (state)
            TX_IDLE:     if (tx_pop) next_state = TX_START;
            TX_START:    if (bit_done) next_state = TX_TRANSMIT;
            TX_TRANSMIT: if (bit_done && last_bit) next_state = TX_STOP;
            TX_STOP:     if (bit_done) next_state = TX_IDLE;
            default:     next_state = TX_IDLE;
        endcase
    end

    always_ff @(posedge clk)
        if (!rstn || !tr_en)
        begin
            counter <= '0;
            bit_cnt <= '0;
            uart_tx <= 1'b1;
        end
        else
            case (state)
                TX_IDLE:
                begin
                    counter <= '0;
                    bit_cnt <= '0;
                    uart_tx <= 1'b1;
                    if (tx_pop)
                    begin
                        shift_reg <= tx_data;
                        uart_tx   <= 1'b0;    // start bit from the pop edge
                    end
                end
                TX_START:
                    if (bit_done)
                    begin
                        counter <= '0;
                        uart_tx <= shift_reg[0];
                    end
                    else
                        counter <= counter + 1'b1;
                TX_TRANSMIT:
                    if (bit_done)
                    begin
                        counter <= '0;
                        if (last_bit)
                            uart_tx <= 1'b1;  // stop bit
                        else
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                            uart_tx <= shift_reg[bit_cnt + 1'b1];
                        end
                    end
                    else
                        counter <= counter + 1'b1;
                TX_STOP:
                    if (bit_done)
                        counter <= '0;
                    else
                        counter <= counter + 1'b1;
                default: counter <= '0;
            endcase

    // the popped byte must not change while it is on the line
    a_shift_stable: assert property (@(posedge clk) disable iff (!rstn)
        (state != TX_IDLE) |=> $stable(shift_reg));

endmodule : uart_transmitter

//--- uart_receiver.sv
// uart 8N1 receiver
// input synchronizer, falling-edge start detect, mid-bit sampling,
// push of each byte with a valid stop bit into the rx FIFO
module uart_receiver
    import uart_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,
    input  logic              rx_en,
    input  logic [BAUD_W-1:0] comp,
    input  logic              uart_rx,
    output logic              rx_push,
    output logic [DATA_W-1:0] rx_push_data
);

    localparam int CNT_W = $clog2(DATA_W);

    rx_state_t         state;
    rx_state_t         next_state;
    logic              rx_sync1;
    logic              rx_sync2;
    logic              rx_prev;      // for edge detect
    logic              fall;
    logic [DATA_W-1:0] shift_reg;
    logic [CNT_W-1:0]  bit_cnt;
    logic [BAUD_W-1:0] counter;
    logic              half_done;
    logic              bit_done;
    logic              last_bit;

    assign fall      = rx_prev && !rx_sync2;
    assign half_done = counter >= (comp >> 1);
    assign bit_done  = counter >= comp;
    assign last_bit  = bit_cnt == CNT_W'(DATA_W - 1);

    // push only when the stop bit sample is high
    assign rx_push      = (state == RX_STOP) && bit_done && rx_sync2;
    assign rx_push_data = shift_reg;

    always_ff @(posedge clk)
        if (!rstn)
        begin
            rx_sync1 <= 1'b1;   // idle line level
            rx_sync2 <= 1'b1;
            rx_prev  <= 1'b1;
        end
        else
        begin
            rx_sync1 <= uart_rx;
            rx_sync2 <= rx_sync1;
            rx_prev  <= rx_sync2;
        end

    always_ff @(posedge clk)
        if (!rstn)
            state <= RX_IDLE;
        else
            state <= rx_en ? next_state : RX_IDLE;

    always_comb
    begin
        next_state = state;
        case (state)
            RX_IDLE:
                if (fall)
                    next_state = RX_START;
            RX_START:                           // recheck at half period
                if (half_done)
                    next_state = rx_sync2 ? RX_IDLE : RX_RECEIVE;
            RX_RECEIVE:
                if (bit_done && last_bit)
                    next_state = RX_STOP;
            RX_STOP:                            // framing error just drops
                if (bit_done)
                    next_state = RX_IDLE;
            default: next_state = RX_IDLE;
        endcase
    end

    always_ff @(posedge clk)
        if (!rstn || !rx_en)
        begin
            counter <= '0;
            bit_cnt <= '0;
        end
        else
            case (state)
                RX_IDLE:
                begin
                    counter <= '0;
                    bit_cnt <= '0;
                end
                RX_START:
                    if (half_done)
                        counter <= '0;   // later samples one period apart
                    else
                        counter <= counter + 1'b1;
                RX_RECEIVE:
                    if (bit_done)
                    begin
                        counter   <= '0;
                        bit_cnt   <= bit_cnt + 1'b1;
                        shift_reg <= {rx_sync2, shift_reg[DATA_W-1:1]};  // LSB first
                    end
                    else
                        counter <= counter + 1'b1;
                RX_STOP:
                    if (bit_done)
                        counter <= '0;
                    else
                        counter <= counter + 1'b1;
                default: counter <= '0;
            endcase

    a_push_single: assert property (@(posedge clk) disable iff (!rstn)
        rx_push |=> !rx_push);

endmodule : uart_receiver

//--- uart_top.sv
// APB uart top level
// register stage, tx and rx FIFOs, transmitter and receiver
module uart_top
    import uart_pkg::*;
    import apb_pkg::*;
#(
    parameter int FIFO_DEPTH = 4   // power of two, 2 or more
)
(
    input  logic              clk,
    input  logic              rstn,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [ADDR_W-1:0] paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              uart_tx,
    input  logic              uart_rx
);

    logic              tx_en;
    logic              rx_en;
    logic [BAUD_W-1:0] comp;
    logic              tx_push;
    logic [DATA_W-1:0] tx_push_data;
    logic              tx_pop;
    logic [DATA_W-1:0] tx_data;
    logic              tx_full;
    logic              tx_empty;
    logic              tx_busy;
    logic              rx_push;
    logic [DATA_W-1:0] rx_push_data;
    logic              rx_pop;
    logic [DATA_W-1:0] rx_data;
    logic              rx_full;
    logic              rx_empty;

    uart_apb_regs u_regs (
        .clk          (clk),
        .rstn         (rstn),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .tx_en        (tx_en),
        .rx_en        (rx_en),
        .comp         (comp),
        .tx_push      (tx_push),
        .tx_push_data (tx_push_data),
        .tx_full      (tx_full),
        .tx_busy      (tx_busy),
        .rx_pop       (rx_pop),
        .rx_data      (rx_data),
        .rx_empty     (rx_empty),
        .rx_full      (rx_full),
        .rx_push_seen (rx_push)
    );

    uart_fifo #(.DEPTH(FIFO_DEPTH)) u_tx_fifo (
        .clk       (clk),
        .rstn      (rstn),
        .push      (tx_push),
        .push_data (tx_push_data),
        .pop       (tx_pop),
        .pop_data  (tx_data),
        .full      (tx_full),
        .empty     (tx_empty)
    );

    uart_fifo #(.DEPTH(FIFO_DEPTH)) u_rx_fifo (
        .clk       (clk),
        .rstn      (rstn),
        .push      (rx_push),
        .push_data (rx_push_data),
        .pop       (rx_pop),
        .pop_data  (rx_data),
        .full      (rx_full),
        .empty     (rx_empty)
    );

    uart_transmitter u_tx (
        .clk      (clk),
        .rstn     (rstn),
        .tr_en    (tx_en),
        .comp     (comp),
        .tx_data  (tx_data),
        .tx_empty (tx_empty),
        .tx_pop   (tx_pop),
        .busy     (tx_busy),
        .uart_tx  (uart_tx)
    );

    uart_receiver u_rx (
        .clk          (clk),
        .rstn         (rstn),
        .rx_en        (rx_en),
        .comp         (comp),
        .uart_rx      (uart_rx),
        .rx_push      (rx_push),
        .rx_push_data (rx_push_data)
    );

endmodule : uart_top

//--- tb_uart.sv
// testbench for the APB uart
// APB read and write tasks, loopback line, uart_tx line monitor,
// frame reference function, compare tasks and a cycle-count timeout
module tb_uart
    import uart_pkg::*;
    import apb_pkg::*;
;

    localparam int FIFO_DEPTH = 4;
    localparam int COMP       = 7;
    localparam int BIT_P      = COMP + 1;          // cycles per bit
    localparam int N_FORMAT   = 8;
    localparam int N_LOOP     = 20;
    localparam int N_BYTES    = N_FORMAT + N_LOOP + FIFO_DEPTH + (FIFO_DEPTH + 1) + 2;
    localparam int TIMEOUT    = (3 * (N_BYTES * 10 * BIT_P + 2000)) / 2;

    logic              clk;
    logic              rstn;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              pslverr;
    logic              uart_tx;
    logic              uart_rx;
    logic              line_ovr;     // testbench owns the rx line
    logic              drv_line;

    logic [31:0]       rng_state;
    int                cycles;
    string             test_name;
    logic              ovr_seen;
    tx_state_t         mon_state;
    logic [9:0]        mon_q[$];     // frames seen on uart_tx
    logic [DATA_W-1:0] tx_exp_q[$];  // bytes accepted into TXDATA
    logic [DATA_W-1:0] rx_exp_q[$];  // bytes expected from RXDATA

    assign uart_rx = line_ovr ? drv_line : uart_tx;   // loopback

    uart_top #(.FIFO_DEPTH(FIFO_DEPTH)) uut (
        .clk     (clk),
        .rstn    (rstn),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .uart_tx (uart_tx),
        .uart_rx (uart_rx)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // expected line sequence, bit 0 goes out first
    function automatic logic [9:0] frame_bits(input logic [DATA_W-1:0] b);
        return {1'b1, b, 1'b0};
    endfunction

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string what, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (exp !== act)
            fail_stop($sformatf("Mismatch %s (%s): expected %h, actual %h",
                                test_name, what, exp, act));
    endtask

    task automatic check_word(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
        if (exp !== act)
            fail_stop($sformatf("Mismatch %s (%s): expected %h, actual %h",
                                test_name, what, exp, act));
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act)
            fail_stop($sformatf("Mismatch %s (%s): expected %b, actual %b",
                                test_name, what, exp, act));
    endtask

    task automatic check_frame(input string what, input logic [9:0] exp,
                               input logic [9:0] act);
        if (exp !== act)
            fail_stop($sformatf("Mismatch %s (%s): expected %b, actual %b",
                                test_name, what, exp, act));
    endtask

    task automatic check_state(input string what, input tx_state_t exp,
                               input tx_state_t act);
        if (exp !== act)
            fail_stop($sformatf("Mismatch %s (%s): expected %s, actual %s",
                                test_name, what, exp.name(), act.name()));
    endtask

    // setup cycle, access cycle, outputs sampled mid access cycle
    task automatic bus_transfer(input logic w, input logic [ADDR_W-1:0] a,
                                input logic [31:0] wd, output logic [31:0] rd,
                                output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= w;
        paddr   <= a;
        pwdata  <= wd;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        check_bit("pready in access cycle", 1'b1, pready);
        rd  = prdata;
        err = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [ADDR_W-1:0] a, input logic [31:0] d,
                             output logic err);
        logic [31:0] unused;
        bus_transfer(1'b1, a, d, unused, err);
    endtask

    task automatic apb_read(input logic [ADDR_W-1:0] a, output logic [31:0] d,
                            output logic err);
        bus_transfer(1'b0, a, 32'h0, d, err);
    endtask

    // remembers the sticky overrun flag since the read clears it
    task automatic read_status(output logic [31:0] st);
        logic err;
        apb_read(REG_STATUS, st, err);
        if (st[ST_RX_OVR])
            ovr_seen = 1'b1;
    endtask

    task automatic tx_send(input logic [DATA_W-1:0] b);
        logic [31:0] st;
        logic        err;
        do
            read_status(st);
        while (st[ST_TX_FULL]);
        apb_write(REG_TXDATA, {24'h0, b}, err);
        check_bit("txdata write accepted", 1'b0, err);
        tx_exp_q.push_back(b);
    endtask

    task automatic rx_take(input string what);
        logic [31:0] st;
        logic [31:0] rd;
        logic        err;
        do
            read_status(st);
        while (st[ST_RX_EMPTY]);
        apb_read(REG_RXDATA, rd, err);
        if (rx_exp_q.size() == 0)
            fail_stop("byte received on RXDATA with none expected");
        else
            check_byte(what, rx_exp_q.pop_front(), rd[DATA_W-1:0]);
    endtask

    task automatic wait_tx_drained();
        logic [31:0] st;
        while (tx_exp_q.size() != 0)
            @(posedge clk);
        do
            read_status(st);
        while (st[ST_TX_BUSY]);
    endtask

    task automatic drive_frame(input logic [DATA_W-1:0] b, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, b, 1'b0};
        @(posedge clk);
        for (int k = 0; k < 10; k++)
        begin
            drv_line <= bits[k];
            repeat (BIT_P) @(posedge clk);
        end
        drv_line <= 1'b1;
    endtask

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT)
            fail_stop($sformatf("timeout after %0d cycles, DUT stopped responding", cycles));
    end

    // samples uart_tx in the middle of each bit after a falling edge
    initial
    begin : line_monitor
        logic [9:0] fr;
        wait (rstn === 1'b1);
        forever
        begin
            mon_state = TX_IDLE;
            @(negedge uart_tx);
            mon_state = TX_START;
            repeat (BIT_P / 2 + 1) @(negedge clk);
            fr[0] = uart_tx;
            check_state("tx FSM at bit center", mon_state, uut.u_tx.state);
            for (int k = 1; k < 10; k++)
            begin
                mon_state = (k == 9) ? TX_STOP : TX_TRANSMIT;
                repeat (BIT_P) @(negedge clk);
                fr[k] = uart_tx;
                check_state("tx FSM at bit center", mon_state, uut.u_tx.state);
            end
            mon_q.push_back(fr);
        end
    end

    always @(posedge clk)
    begin : frame_compare
        logic [9:0]        fr;
        logic [DATA_W-1:0] b;
        if (mon_q.size() != 0)
        begin
            fr = mon_q.pop_front();
            if (tx_exp_q.size() == 0)
                fail_stop("frame seen on uart_tx with no byte written");
            else
            begin
                b = tx_exp_q.pop_front();
                check_frame("uart_tx frame", frame_bits(b), fr);
            end
        end
    end

    initial
    begin : main
        logic [31:0]       rd;
        logic [31:0]       st;
        logic [31:0]       r;
        logic              err;
        clk       = 1'b0;
        rstn      = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        line_ovr  = 1'b0;
        drv_line  = 1'b1;
        rng_state = 32'hdeb9a8ba;
        cycles    = 0;
        ovr_seen  = 1'b0;
        mon_state = TX_IDLE;
        repeat (16) @(posedge clk);
        rstn <= 1'b1;

        test_name = "reset and readback";
        check_bit("uart_tx idle high", 1'b1, uart_tx);
        apb_read(REG_CTRL, rd, err);
        check_word("ctrl reset", 32'h0, rd);
        apb_read(REG_BAUD, rd, err);
        check_word("baud reset", 32'h0, rd);
        read_status(st);
        check_word("status reset", 32'h1 << ST_RX_EMPTY, st);
        apb_write(REG_BAUD, 32'h1234_a5c3, err);
        apb_read(REG_BAUD, rd, err);
        check_word("baud readback", 32'h0000_a5c3, rd);   // only 16 bits held
        apb_write(REG_CTRL, 32'h3, err);
        apb_read(REG_CTRL, rd, err);
        check_word("ctrl readback", 32'h3, rd);
        apb_write(REG_CTRL, 32'h1, err);                   // tx only
        apb_write(REG_BAUD, COMP, err);
        apb_read(REG_BAUD, rd, err);
        check_word("baud readback", COMP, rd);

        test_name = "frame format";
        for (int i = 0; i < N_FORMAT; i++)
        begin
            r = next_rand();
            tx_send(r[23:16]);
        end
        wait_tx_drained();

        test_name = "loopback";
        apb_write(REG_CTRL, 32'h3, err);
        for (int i = 0; i < N_LOOP; i++)
        begin
            r = next_rand();
            rx_exp_q.push_back(r[23:16]);
            tx_send(r[23:16]);
            rx_take("loopback byte");
        end
        wait_tx_drained();

        test_name = "back-pressure";
        apb_write(REG_CTRL, 32'h2, err);                   // hold the transmitter
        for (int i = 0; i < FIFO_DEPTH; i++)
        begin
            r = next_rand();
            apb_write(REG_TXDATA, {24'h0, r[23:16]}, err);
            check_bit("txdata write with room", 1'b0, err);
            tx_exp_q.push_back(r[23:16]);
            rx_exp_q.push_back(r[23:16]);
        end
        read_status(st);
        check_bit("tx full flag", 1'b1, st[ST_TX_FULL]);
        r = next_rand();
        apb_write(REG_TXDATA, {24'h0, r[23:16]}, err);
        check_bit("txdata write while full", 1'b1, err);
        apb_write(REG_CTRL, 32'h3, err);
        for (int i = 0; i < FIFO_DEPTH; i++)
            rx_take("queued byte");
        wait_tx_drained();
        read_status(st);
        check_bit("rx empty after queued bytes", 1'b1, st[ST_RX_EMPTY]);
        check_bit("no overrun so far", 1'b0, ovr_seen);

        test_name = "overrun and errors";
        for (int i = 0; i <= FIFO_DEPTH; i++)
        begin
            r = next_rand();
            tx_send(r[23:16]);
            if (i < FIFO_DEPTH)
                rx_exp_q.push_back(r[23:16]);   // the last one is dropped
        end
        while (!ovr_seen)
            read_status(st);
        read_status(st);
        check_bit("overrun cleared by status read", 1'b0, st[ST_RX_OVR]);
        for (int i = 0; i < FIFO_DEPTH; i++)
            rx_take("byte before overrun");
        read_status(st);
        check_bit("dropped byte not stored", 1'b1, st[ST_RX_EMPTY]);
        apb_read(REG_RXDATA, rd, err);
        check_word("rxdata read when empty", 32'h0, rd);
        wait_tx_drained();
        apb_read(8'h14, rd, err);
        check_bit("unmapped read error", 1'b1, err);
        apb_write(8'h20, 32'h0, err);
        check_bit("unmapped write error", 1'b1, err);
        apb_read(REG_CTRL, rd, err);
        check_word("ctrl after failed write", 32'h3, rd);

        test_name = "framing error";
        @(posedge clk);
        line_ovr <= 1'b1;
        r = next_rand();
        drive_frame(r[23:16], 1'b0);
        repeat (20 * BIT_P) @(posedge clk);   // two frame times
        read_status(st);
        check_bit("frame with bad stop bit dropped", 1'b1, st[ST_RX_EMPTY]);
        r = next_rand();
        rx_exp_q.push_back(r[23:16]);
        drive_frame(r[23:16], 1'b1);
        rx_take("good frame after framing error");
        @(posedge clk);
        line_ovr <= 1'b0;

        if (rx_exp_q.size() != 0 || tx_exp_q.size() != 0 || mon_q.size() != 0)
            fail_stop("bytes still outstanding at the end of the run");
        else
        begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule : tb_uart

//--- filelist.f
uart_pkg.sv
apb_pkg.sv
uart_fifo.sv
uart_apb_regs.sv
uart_transmitter.sv
uart_receiver.sv
uart_top.sv
tb_uart.sv
